//--- common/sched_geom_pkg.sv
package sched_geom_pkg;

    // Upper bounds on the scheduler shape; real sizes come from the top level parameters
    localparam int MAX_RS_ENTRIES = 16;
    localparam int MAX_FUS        = 4;

    localparam int ENTRY_IDX_W = $clog2(MAX_RS_ENTRIES);  // 4 bits
    localparam int FU_ID_W     = $clog2(MAX_FUS);         // 2 bits
    localparam int PROD_TAG_W  = FU_ID_W + ENTRY_IDX_W;   // {fu, entry}

    typedef logic [ENTRY_IDX_W-1:0] entry_idx_t;  // Reservation station slot
    typedef logic [FU_ID_W-1:0]     fu_id_t;      // Functional unit number
    typedef logic [PROD_TAG_W-1:0]  prod_tag_t;   // Where a producer lives

    // Functional unit field sits in the upper bits of a tag
    function automatic fu_id_t tag_fu(prod_tag_t tag);
        return tag[PROD_TAG_W-1 -: FU_ID_W];
    endfunction

    // Entry field, lower bits
    function automatic entry_idx_t tag_entry(prod_tag_t tag);
        return tag[ENTRY_IDX_W-1:0];
    endfunction

endpackage

//--- common/uop_pkg.sv
package uop_pkg;

    localparam int LATENCY_W = 4;
    localparam int SRC_REF_W = 1 + sched_geom_pkg::PROD_TAG_W;  // Valid bit plus tag

    typedef logic [LATENCY_W-1:0] latency_t;  // Grant to result usable, in cycles
    typedef logic [SRC_REF_W-1:0] src_ref_t;  // {valid, fu, entry}

    function automatic logic src_valid(src_ref_t src);
        return src[SRC_REF_W-1];
    endfunction

    function automatic sched_geom_pkg::prod_tag_t src_tag(src_ref_t src);
        return src[sched_geom_pkg::PROD_TAG_W-1:0];
    endfunction

    // A zero latency op still needs one cycle before its column clears
    function automatic latency_t eff_latency(latency_t lat);
        return (lat == '0) ? latency_t'(1) : lat;
    endfunction

endpackage

//--- common/wakeup_dispatch_if.sv
`timescale 1ns/1ps

// Dispatch side of the wakeup block
// Accepted when dispatch_valid and entry_free are both high; slot is entry_index that cycle
interface wakeup_dispatch_if;

    logic                       dispatch_valid;
    uop_pkg::src_ref_t          src1;          // First operand producer
    uop_pkg::src_ref_t          src2;          // Second operand producer
    sched_geom_pkg::fu_id_t     fu;            // Unit this micro-op runs on
    uop_pkg::latency_t          latency;
    logic                       entry_free;    // Free queue not empty
    sched_geom_pkg::entry_idx_t entry_index;   // Free queue head

    modport source (
        output dispatch_valid, src1, src2, fu, latency,
        input  entry_free, entry_index
    );

    modport wakeup (
        input  dispatch_valid, src1, src2, fu, latency,
        output entry_free, entry_index
    );

endinterface

//--- wakeup/dependency_matrix.sv
`timescale 1ns/1ps

// Dependency bits for one functional unit
// Row is the waiting entry, column is the producer entry
module dependency_matrix #(
    parameter int rows = 8,
    parameter int cols = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       w_en,        // Allocate and load a row
    input  sched_geom_pkg::entry_idx_t w_row,
    input  logic [cols-1:0]            set_cols,    // Producers this row waits on
    input  logic [cols-1:0]            clear_col,   // Producers whose results are ready
    input  logic                       free_en,     // Entry completed
    input  sched_geom_pkg::entry_idx_t free_row,
    output logic [rows-1:0]            row_pending
);

    logic [cols-1:0] dep_bits [rows];
    logic [cols-1:0] dep_next [rows];

    always_comb begin
        for (int r = 0; r < rows; r++) begin
            // Broadcast clear reaches every row
            dep_next[r] = dep_bits[r] & ~clear_col;

            if (free_en && (free_row == sched_geom_pkg::entry_idx_t'(r))) begin
                dep_next[r] = '0;  // Row no longer holds a micro-op
            end

            // New row, minus producers that wake up this very cycle
            if (w_en && (w_row == sched_geom_pkg::entry_idx_t'(r))) begin
                dep_next[r] = set_cols & ~clear_col;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < rows; r++) begin
                dep_bits[r] <= '0;
            end
        end else begin
            for (int r = 0; r < rows; r++) begin
                dep_bits[r] <= dep_next[r];
            end
        end
    end

    // Any set bit keeps the row waiting
    always_comb begin
        for (int r = 0; r < rows; r++) begin
            row_pending[r] = |dep_bits[r];
        end
    end

endmodule

//--- wakeup/free_entry_queue.sv
`timescale 1ns/1ps

// Circular queue of free reservation station slots
// Starts full with 0..depth-1 so the first allocations come out in order
module free_entry_queue #(
    parameter int depth = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,        // Completed entry returns
    input  sched_geom_pkg::entry_idx_t push_index,
    input  logic                       pop,         // Dispatch takes the head
    output sched_geom_pkg::entry_idx_t head,
    output logic                       empty
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    sched_geom_pkg::entry_idx_t slots [depth];
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W-1:0]           wr_ptr;
    logic [CNT_W-1:0]           count;
    logic                       do_pop;

    // Wrap explicitly, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty  = (count == '0);
    assign do_pop = pop && !empty;     // Pop on empty is ignored
    assign head   = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                slots[i] <= sched_geom_pkg::entry_idx_t'(i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;              // Full, so write pointer meets read pointer
            count  <= CNT_W'(depth);
        end else begin
            if (push) begin
                slots[wr_ptr] <= push_index;
                wr_ptr        <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- wakeup/issue_select.sv
`timescale 1ns/1ps

// Fixed priority select, lowest requesting index wins
// One grant per cycle, registered, so issue follows a request by one cycle
module issue_select #(
    parameter int rs_entries = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [rs_entries-1:0]      request_vector,
    output logic                       grant_valid,
    output sched_geom_pkg::entry_idx_t grant_index
);

    logic                       pick_valid;
    sched_geom_pkg::entry_idx_t pick_index;

    // Scan from the top down so the last hit is the lowest index
    always_comb begin
        pick_valid = 1'b0;
        pick_index = '0;
        for (int i = rs_entries - 1; i >= 0; i--) begin
            if (request_vector[i]) begin
                pick_valid = 1'b1;
                pick_index = sched_geom_pkg::entry_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant_index <= '0;
        end else begin
            grant_valid <= pick_valid;
            grant_index <= pick_index;   // Held value is don't care without grant_valid
        end
    end

endmodule

//--- wakeup/wakeup_logic.sv
`timescale 1ns/1ps

// Allocation, dependency tracking and speculative wakeup for the issue queue
// A granted producer counts down its latency, then clears its column everywhere
module wakeup_logic #(
    parameter int rs_entries = 8,
    parameter int num_fus    = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    wakeup_dispatch_if.wakeup          dispatch,
    input  logic                       grant_valid,
    input  sched_geom_pkg::entry_idx_t grant_index,
    input  logic                       complete_valid,
    input  sched_geom_pkg::entry_idx_t complete_index,
    output logic [rs_entries-1:0]      request_vector,
    output sched_geom_pkg::fu_id_t     issue_fu
);

    sched_geom_pkg::fu_id_t             entry_fu  [rs_entries];
    uop_pkg::latency_t                  entry_lat [rs_entries];
    uop_pkg::latency_t                  countdown [rs_entries];
    logic [rs_entries-1:0]              live;       // Slot holds a micro-op
    logic [rs_entries-1:0]              selected;   // Issued, waiting for completion
    logic [rs_entries-1:0]              counting;
    logic [rs_entries-1:0]              done;       // Result already broadcast
    logic [rs_entries-1:0]              expire;     // Countdown hits zero this cycle
    logic [rs_entries-1:0]              satisfied;  // Consumers need no bit for this producer
    logic [rs_entries-1:0]              pending;
    logic [num_fus-1:0][rs_entries-1:0] set_cols;
    logic [num_fus-1:0][rs_entries-1:0] fu_pending;
    uop_pkg::src_ref_t                  srcs [2];
    logic                               alloc;
    sched_geom_pkg::entry_idx_t         alloc_index;
    logic                               queue_empty;

    assign dispatch.entry_free  = !queue_empty;
    assign dispatch.entry_index = alloc_index;
    assign alloc   = dispatch.dispatch_valid && !queue_empty;
    assign srcs[0] = dispatch.src1;
    assign srcs[1] = dispatch.src2;

    free_entry_queue #(
        .depth(rs_entries)
    ) u_free_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (complete_valid),
        .push_index(complete_index),
        .pop       (alloc),
        .head      (alloc_index),
        .empty     (queue_empty)
    );

    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            expire[i] = counting[i] && (countdown[i] == uop_pkg::latency_t'(1));
        end
    end

    // Freed, already woken, or waking now
    assign satisfied = ~live | done | expire;

    // Matrix picked by the source's unit, column by its entry
    always_comb begin
        set_cols = '0;
        for (int s = 0; s < 2; s++) begin
            for (int f = 0; f < num_fus; f++) begin
                for (int j = 0; j < rs_entries; j++) begin
                    if (uop_pkg::src_valid(srcs[s]) && !satisfied[j]
                        && (sched_geom_pkg::tag_fu(uop_pkg::src_tag(srcs[s]))
                            == sched_geom_pkg::fu_id_t'(f))
                        && (sched_geom_pkg::tag_entry(uop_pkg::src_tag(srcs[s]))
                            == sched_geom_pkg::entry_idx_t'(j))) begin
                        set_cols[f][j] = 1'b1;
                    end
                end
            end
        end
    end

    // Column j only ever holds bits in its producer's unit matrix, so one clear vector serves all
    for (genvar f = 0; f < num_fus; f++) begin : g_matrix
        dependency_matrix #(
            .rows(rs_entries),
            .cols(rs_entries)
        ) u_matrix (
            .clk        (clk),
            .rst        (rst),
            .w_en       (alloc),
            .w_row      (alloc_index),
            .set_cols   (set_cols[f]),
            .clear_col  (expire),
            .free_en    (complete_valid),
            .free_row   (complete_index),
            .row_pending(fu_pending[f])
        );
    end

    always_comb begin
        pending = '0;
        for (int f = 0; f < num_fus; f++) begin
            pending = pending | fu_pending[f];
        end
    end

    // The entry on the grant register this cycle gets its selected flag only at the edge
    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            request_vector[i] = live[i] && !pending[i] && !selected[i]
                && !(grant_valid && (grant_index == sched_geom_pkg::entry_idx_t'(i)));
        end
    end

    always_comb begin
        issue_fu = '0;
        for (int i = 0; i < rs_entries; i++) begin
            if (grant_index == sched_geom_pkg::entry_idx_t'(i)) begin
                issue_fu = entry_fu[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_entries; i++) begin
            if (alloc && (alloc_index == sched_geom_pkg::entry_idx_t'(i))) begin
                entry_fu[i]  <= dispatch.fu;
                entry_lat[i] <= dispatch.latency;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live     <= '0;
            selected <= '0;
            counting <= '0;
            done     <= '0;
            for (int i = 0; i < rs_entries; i++) begin
                countdown[i] <= '0;
            end
        end else begin
            for (int i = 0; i < rs_entries; i++) begin
                if (expire[i]) begin
                    counting[i] <= 1'b0;
                    done[i]     <= 1'b1;
                end
                if (counting[i]) begin
                    countdown[i] <= countdown[i] - 1'b1;
                end
                // Grant starts the latency count
                if (grant_valid && (grant_index == sched_geom_pkg::entry_idx_t'(i))) begin
                    selected[i]  <= 1'b1;
                    counting[i]  <= 1'b1;
                    done[i]      <= 1'b0;
                    countdown[i] <= uop_pkg::eff_latency(entry_lat[i]);
                end
                if (complete_valid && (complete_index == sched_geom_pkg::entry_idx_t'(i))) begin
                    live[i]     <= 1'b0;
                    selected[i] <= 1'b0;
                end
                if (alloc && (alloc_index == sched_geom_pkg::entry_idx_t'(i))) begin
                    live[i]     <= 1'b1;   // New occupant starts clean
                    selected[i] <= 1'b0;
                    counting[i] <= 1'b0;
                    done[i]     <= 1'b0;
                end
            end
        end
    end

endmodule

//--- hw/issue_sched_top.sv
`timescale 1ns/1ps

// Wakeup and select stage of the issue queue
module issue_sched_top #(
    parameter int rs_entries = 8,
    parameter int num_fus    = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dispatch_valid,
    input  logic                       src1_valid,
    input  sched_geom_pkg::prod_tag_t  src1_tag,
    input  logic                       src2_valid,
    input  sched_geom_pkg::prod_tag_t  src2_tag,
    input  sched_geom_pkg::fu_id_t     dispatch_fu,
    input  uop_pkg::latency_t          dispatch_latency,
    input  logic                       complete_valid,     // Execute finished an entry
    input  sched_geom_pkg::entry_idx_t complete_index,
    output logic                       entry_free,
    output sched_geom_pkg::entry_idx_t entry_index,
    output logic                       issue_valid,
    output sched_geom_pkg::entry_idx_t issue_index,
    output sched_geom_pkg::fu_id_t     issue_fu
);

    wakeup_dispatch_if     dispatch_bus ();
    logic [rs_entries-1:0] request_vector;

    // Pack the flat dispatch ports onto the bus
    assign dispatch_bus.dispatch_valid = dispatch_valid;
    assign dispatch_bus.src1           = {src1_valid, src1_tag};
    assign dispatch_bus.src2           = {src2_valid, src2_tag};
    assign dispatch_bus.fu             = dispatch_fu;
    assign dispatch_bus.latency        = dispatch_latency;
    assign entry_free                  = dispatch_bus.entry_free;
    assign entry_index                 = dispatch_bus.entry_index;

    wakeup_logic #(
        .rs_entries(rs_entries),
        .num_fus   (num_fus)
    ) u_wakeup (
        .clk           (clk),
        .rst           (rst),
        .dispatch      (dispatch_bus.wakeup),
        .grant_valid   (issue_valid),
        .grant_index   (issue_index),
        .complete_valid(complete_valid),
        .complete_index(complete_index),
        .request_vector(request_vector),
        .issue_fu      (issue_fu)
    );

    // Registered grant is the issue itself
    issue_select #(
        .rs_entries(rs_entries)
    ) u_select (
        .clk           (clk),
        .rst           (rst),
        .request_vector(request_vector),
        .grant_valid   (issue_valid),
        .grant_index   (issue_index)
    );

endmodule

//--- tests/issue_sched_tb.sv
`timescale 1ns/1ps

// Pattern driven testbench for the issue queue wakeup and select stage
module issue_sched_tb;

    localparam int MAX_RECS = 48;
    localparam int MAX_IDS  = 16;
    localparam int ENTRIES  = 8;

    logic                       clk;
    logic                       rst;
    logic                       dispatch_valid;
    logic                       src1_valid;
    sched_geom_pkg::prod_tag_t  src1_tag;
    logic                       src2_valid;
    sched_geom_pkg::prod_tag_t  src2_tag;
    sched_geom_pkg::fu_id_t     dispatch_fu;
    uop_pkg::latency_t          dispatch_latency;
    logic                       complete_valid;
    sched_geom_pkg::entry_idx_t complete_index;
    logic                       entry_free;
    sched_geom_pkg::entry_idx_t entry_index;
    logic                       issue_valid;
    sched_geom_pkg::entry_idx_t issue_index;
    sched_geom_pkg::fu_id_t     issue_fu;

    logic [31:0] recs [MAX_RECS];  // One hex digit per field
    int ent_of    [MAX_IDS];       // Entry index handed out at acceptance
    int fu_of     [MAX_IDS];
    int lat_of    [MAX_IDS];
    int src_of    [MAX_IDS][2];    // Producer local ids, -1 for none
    int accept_at [MAX_IDS];       // -1 until dispatched
    int issue_at  [MAX_IDS];       // -1 until issued
    bit early     [MAX_IDS];       // All sources resolved when accepted
    bit gone      [MAX_IDS];       // Completed
    int id_at     [ENTRIES];       // Local id in each entry, -1 when free
    int free_q [$];                // Expected allocation order
    int cycle = 0;
    int limit = 100000;
    int last_idle;                 // Last cycle without an issue
    int nrec;
    int seed;
    int gap;
    int issue_errors;
    int flow_errors;

    issue_sched_top uut (
        .clk(clk), .rst(rst), .dispatch_valid(dispatch_valid),
        .src1_valid(src1_valid), .src1_tag(src1_tag),
        .src2_valid(src2_valid), .src2_tag(src2_tag),
        .dispatch_fu(dispatch_fu), .dispatch_latency(dispatch_latency),
        .complete_valid(complete_valid), .complete_index(complete_index),
        .entry_free(entry_free), .entry_index(entry_index),
        .issue_valid(issue_valid), .issue_index(issue_index), .issue_fu(issue_fu)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Latency 0 still takes one cycle
    function automatic int usable_delay(int lat);
        return (lat == 0) ? 1 : lat;
    endfunction

    function automatic sched_geom_pkg::prod_tag_t tag_of(int p);
        if (p < 0) begin
            return '0;
        end
        return {sched_geom_pkg::fu_id_t'(fu_of[p]), sched_geom_pkg::entry_idx_t'(ent_of[p])};
    endfunction

    // Producer freed, absent, or past its countdown
    function automatic bit resolved(int p);
        if (p < 0 || gone[p]) begin
            return 1'b1;
        end
        return issue_at[p] >= 0 && cycle >= issue_at[p] + usable_delay(lat_of[p]);
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("Timeout: %0d cycles passed before the record list finished", limit);
            $display("Issue errors: %0d, flow errors: %0d", issue_errors, flow_errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_issue(input int e, input int fu);
        int id;
        int p;
        int other;
        id = id_at[e];
        if (id < 0) begin
            $display("Error at %0t: entry %0d issued while it holds no micro-op", $time, e);
            issue_errors++;
            return;
        end
        if (issue_at[id] >= 0) begin
            $display("Error at %0t: op %0d in entry %0d issued twice", $time, id, e);
            issue_errors++;
        end
        if (fu != fu_of[id]) begin
            $display("Error at %0t: op %0d issue_fu %0d, expected %0d",
                     $time, id, fu, fu_of[id]);
            issue_errors++;
        end
        for (int s = 0; s < 2; s++) begin
            p = src_of[id][s];
            if (p >= 0 && !early[id]) begin  // Must sit out the producer latency
                if (issue_at[p] < 0 || cycle < issue_at[p] + usable_delay(lat_of[p])) begin
                    $display("Error at %0t: op %0d issued before producer %0d was usable",
                             $time, id, p);
                    issue_errors++;
                end
            end
        end
        // A ready op only waits while the selector is busy every cycle
        if (early[id] && last_idle >= accept_at[id] + 2) begin
            $display("Error at %0t: ready op %0d was left waiting while select was idle",
                     $time, id);
            issue_errors++;
        end
        for (int k = 0; k < e; k++) begin
            other = id_at[k];
            if (other >= 0 && early[other] && issue_at[other] < 0
                && accept_at[other] + 2 <= cycle) begin
                $display("Error at %0t: entry %0d issued ahead of ready entry %0d", $time, e, k);
                issue_errors++;
            end
        end
        issue_at[id] = cycle;
    endtask

    // Outputs are sampled mid cycle
    always @(negedge clk) begin
        if (rst) begin
            issue_errors = 0;
            last_idle    = 0;
            for (int i = 0; i < MAX_IDS; i++) begin
                issue_at[i] = -1;
            end
        end else if (issue_valid) begin
            check_issue(int'(issue_index), int'(issue_fu));
        end else begin
            last_idle = cycle;
        end
    end

    task automatic dispatch_op(input logic [31:0] rec);
        int id;
        int e;
        int expected;
        id = int'(rec[27:24]);
        src_of[id][0] = (rec[23:20] != 4'h0) ? int'(rec[19:16]) : -1;
        src_of[id][1] = (rec[15:12] != 4'h0) ? int'(rec[11:8]) : -1;
        fu_of[id]  = int'(rec[7:4]);
        lat_of[id] = int'(rec[3:0]);
        @(posedge clk);
        dispatch_valid   <= 1'b1;
        src1_valid       <= (src_of[id][0] >= 0);
        src1_tag         <= tag_of(src_of[id][0]);
        src2_valid       <= (src_of[id][1] >= 0);
        src2_tag         <= tag_of(src_of[id][1]);
        dispatch_fu      <= sched_geom_pkg::fu_id_t'(rec[7:4]);
        dispatch_latency <= rec[3:0];
        @(negedge clk);
        while (!entry_free) begin  // Held until a slot frees up
            @(negedge clk);
        end
        e = int'(entry_index);
        expected = -1;
        if (free_q.size() != 0) begin
            expected = free_q.pop_front();
        end
        if (e != expected) begin
            $display("Error at %0t: op %0d got entry %0d, expected %0d", $time, id, e, expected);
            flow_errors++;
        end
        ent_of[id]    = e;
        accept_at[id] = cycle;
        early[id]     = resolved(src_of[id][0]) && resolved(src_of[id][1]);
        id_at[e]      = id;
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    task automatic complete_op(input int id);
        while (issue_at[id] < 0) begin  // Execute only returns issued ops
            @(negedge clk);
        end
        @(posedge clk);
        complete_valid <= 1'b1;
        complete_index <= sched_geom_pkg::entry_idx_t'(ent_of[id]);
        @(negedge clk);
        gone[id]           = 1'b1;
        id_at[ent_of[id]]  = -1;
        free_q.push_back(ent_of[id]);  // Tail of the free queue
        @(posedge clk);
        complete_valid <= 1'b0;
    endtask

    // Dispatch is offered for a few cycles and must not be taken
    task automatic check_full();
        @(posedge clk);
        dispatch_valid <= 1'b1;
        src1_valid     <= 1'b0;
        src2_valid     <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (entry_free) begin
                $display("Error at %0t: entry_free high with every entry in use", $time);
                flow_errors++;
            end
        end
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    initial begin
        seed             = 99159;
        flow_errors      = 0;
        rst              = 1'b1;
        dispatch_valid   = 1'b0;
        src1_valid       = 1'b0;
        src1_tag         = '0;
        src2_valid       = 1'b0;
        src2_tag         = '0;
        dispatch_fu      = '0;
        dispatch_latency = '0;
        complete_valid   = 1'b0;
        complete_index   = '0;
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = '0;
        end
        for (int i = 0; i < MAX_IDS; i++) begin
            accept_at[i] = -1;
            gone[i]      = 1'b0;
            early[i]     = 1'b0;
        end
        for (int e = 0; e < ENTRIES; e++) begin
            id_at[e] = -1;
            free_q.push_back(e);  // Reset order 0..7
        end
        $readmemh("tests/wakeup_patterns.mem", recs);
        nrec = 0;
        while (nrec < MAX_RECS && recs[nrec][31:28] != 4'h0) begin
            nrec++;
        end
        limit = nrec * 40;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!entry_free || issue_valid) begin
            $display("Error at %0t: after reset entry_free %b issue_valid %b",
                     $time, entry_free, issue_valid);
            flow_errors++;
        end
        for (int r = 0; r < nrec; r++) begin
            case (recs[r][31:28])
                4'h1: dispatch_op(recs[r]);
                4'h2: complete_op(int'(recs[r][27:24]));
                4'h3: repeat (int'(recs[r][7:0])) @(posedge clk);
                4'h4: check_full();
                default: begin
                    $display("Record %0d has an unknown op code", r);
                    flow_errors++;
                end
            endcase
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
        end
        for (int i = 0; i < MAX_IDS; i++) begin
            if (accept_at[i] >= 0 && issue_at[i] < 0) begin
                $display("Op %0d was dispatched but never issued", i);
                flow_errors++;
            end
        end
        $display("Issue errors: %0d, flow errors: %0d", issue_errors, flow_errors);
        if (issue_errors == 0 && flow_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/wakeup_patterns.mem
// Columns, one hex digit each: op, id, src1 valid, src1 id, src2 valid, src2 id, fu, latency
// op 1 dispatch, 2 complete, 3 wait (low byte is cycles), 4 expect full, 0 ends the list
10000001 // id0 fu0 lat1
11000013 // id1 fu1 lat3
12000002 // id2 fu0 lat2
13000012 // id3 fu1 lat2
14000004 // id4 fu0 lat4
15000011 // id5 fu1 lat1
16000000 // id6 fu0 lat0
17000015 // id7 fu1 lat5
40000000 // all eight entries taken
20000000 // complete id0
22000000 // complete id2
21000000 // complete id1
23000000 // complete id3
18000005 // id8 fu0 lat5
19180012 // id9 waits on id8
1a000017 // id10 fu1 lat7
1b181a02 // id11 waits on id8 and id10
30000020 // wait 32 cycles
25000000 // complete id5
1c150000 // id12 on completed id5
26000000 // complete id6
1d191411 // id13 on expired id9 and id4
30000010 // wait 16 cycles
27000000 // complete id7
24000000 // complete id4
1e1c0003 // id14 on expired id12
1f000016 // id15 fu1 lat6
30000020 // drain
00000000

//--- project.f
common/sched_geom_pkg.sv
common/uop_pkg.sv
common/wakeup_dispatch_if.sv
wakeup/dependency_matrix.sv
wakeup/free_entry_queue.sv
wakeup/issue_select.sv
wakeup/wakeup_logic.sv
hw/issue_sched_top.sv
tests/issue_sched_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the issue scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module issue_sched_tb -f project.f \
    --Mdir obj_dir -o issue_sched_sim

./obj_dir/issue_sched_sim > sim.log
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
